// File: source/cpu_core_pkg.sv
`default_nettype none

package cpu_core_pkg;

  localparam int xlen = 32;

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic [6:0] {
    opcode_lui    = 7'b0110111,
    opcode_auipc  = 7'b0010111,
    opcode_jal    = 7'b1101111,
    opcode_jalr   = 7'b1100111,
    opcode_branch = 7'b1100011,
    opcode_load   = 7'b0000011,
    opcode_store  = 7'b0100011,
    opcode_op_imm = 7'b0010011,
    opcode_op     = 7'b0110011,
    opcode_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    size_byte = 2'b00, // Same as funct3[1:0] of loads and stores.
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_e;

  typedef enum logic [1:0] {wb_alu, wb_memory, wb_link} wb_source_e;

  // ------------------------------
  // Instruction formats
  // ------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_type_t;

  typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
    s_type_t s_type;
    b_type_t b_type;
    u_type_t u_type;
    j_type_t j_type;
  } instr_word_u;

  // ------------------------------
  // Pipeline and bus records
  // ------------------------------
  typedef struct packed {
    opcode_e    opcode;
    alu_op_e    alu_op;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [xlen-1:0] imm;
    logic       use_imm;
    logic       use_pc_a;
    logic       is_branch;
    logic       is_jump;
    logic       mem_read;
    logic       mem_write;
    mem_size_e  mem_size;
    logic       mem_unsigned;
    logic       reg_write;
    wb_source_e wb_source;
    logic       halt;
  } decoded_instr_t;

  typedef struct packed {
    logic [xlen-1:0] alu_value;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] link;
    logic            taken;
  } exec_result_t;

  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic            we;
    logic [xlen-1:0] adr;
    logic [xlen-1:0] dat;
    logic [3:0]      sel;
  } wb_request_t;

  typedef struct packed {
    logic            ack;
    logic [xlen-1:0] dat;
  } wb_response_t;

endpackage

`default_nettype wire

// File: source/instruction_decode.sv
`default_nettype none

module instruction_decode (
  input  wire cpu_core_pkg::instr_word_u instruction,
  output cpu_core_pkg::decoded_instr_t   decoded
);

  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = instruction.r_type.funct3;
  assign funct7 = instruction.r_type.funct7;

  function automatic cpu_core_pkg::alu_op_e alu_select(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? cpu_core_pkg::alu_sub : cpu_core_pkg::alu_add;
      3'b001:  return cpu_core_pkg::alu_sll;
      3'b010:  return cpu_core_pkg::alu_slt;
      3'b011:  return cpu_core_pkg::alu_sltu;
      3'b100:  return cpu_core_pkg::alu_xor;
      3'b101:  return alt ? cpu_core_pkg::alu_sra : cpu_core_pkg::alu_srl;
      3'b110:  return cpu_core_pkg::alu_or;
      default: return cpu_core_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    decoded = '0;
    decoded.opcode = instruction.r_type.opcode;
    decoded.rd = instruction.r_type.rd;
    decoded.rs1 = instruction.r_type.rs1;
    decoded.rs2 = instruction.r_type.rs2;
    decoded.alu_op = cpu_core_pkg::alu_add;
    decoded.mem_size = cpu_core_pkg::size_word;
    decoded.wb_source = cpu_core_pkg::wb_alu;
    case (instruction.r_type.opcode)
      cpu_core_pkg::opcode_lui, cpu_core_pkg::opcode_auipc: begin
        decoded.imm = {instruction.u_type.imm_31_12, 12'b0};
        decoded.use_imm = 1'b1;
        decoded.use_pc_a = instruction.r_type.opcode == cpu_core_pkg::opcode_auipc;
        decoded.reg_write = 1'b1;
        if (instruction.r_type.opcode == cpu_core_pkg::opcode_lui)
          decoded.alu_op = cpu_core_pkg::alu_pass_b;
      end
      cpu_core_pkg::opcode_jal: begin
        decoded.imm = {{11{instruction.j_type.imm_20}}, instruction.j_type.imm_20,
                       instruction.j_type.imm_19_12, instruction.j_type.imm_11,
                       instruction.j_type.imm_10_1, 1'b0};
        decoded.is_jump = 1'b1;
        decoded.reg_write = 1'b1;
        decoded.wb_source = cpu_core_pkg::wb_link;
      end
      cpu_core_pkg::opcode_jalr: begin
        decoded.imm = {{20{instruction.i_type.imm_11_0[11]}}, instruction.i_type.imm_11_0};
        decoded.use_imm = 1'b1; // The ALU forms rs1 + imm as the target.
        decoded.is_jump = 1'b1;
        decoded.reg_write = 1'b1;
        decoded.wb_source = cpu_core_pkg::wb_link;
        decoded.halt = funct3 != 3'b000;
      end
      cpu_core_pkg::opcode_branch: begin
        decoded.imm = {{19{instruction.b_type.imm_12}}, instruction.b_type.imm_12,
                       instruction.b_type.imm_11, instruction.b_type.imm_10_5,
                       instruction.b_type.imm_4_1, 1'b0};
        decoded.is_branch = 1'b1;
        decoded.rd = {2'b00, funct3}; // Branches have no rd, so it carries the condition.
        decoded.halt = funct3[2:1] == 2'b01;
      end
      cpu_core_pkg::opcode_load: begin
        decoded.imm = {{20{instruction.i_type.imm_11_0[11]}}, instruction.i_type.imm_11_0};
        decoded.use_imm = 1'b1;
        decoded.mem_read = 1'b1;
        decoded.mem_size = cpu_core_pkg::mem_size_e'(funct3[1:0]);
        decoded.mem_unsigned = funct3[2];
        decoded.reg_write = 1'b1;
        decoded.wb_source = cpu_core_pkg::wb_memory;
        decoded.halt = funct3[1:0] == 2'b11 || funct3[2:1] == 2'b11;
      end
      cpu_core_pkg::opcode_store: begin
        decoded.imm = {{20{instruction.s_type.imm_11_5[6]}}, instruction.s_type.imm_11_5,
                       instruction.s_type.imm_4_0};
        decoded.use_imm = 1'b1;
        decoded.mem_write = 1'b1;
        decoded.mem_size = cpu_core_pkg::mem_size_e'(funct3[1:0]);
        decoded.halt = funct3[2] || funct3[1:0] == 2'b11;
      end
      cpu_core_pkg::opcode_op_imm: begin
        decoded.imm = {{20{instruction.i_type.imm_11_0[11]}}, instruction.i_type.imm_11_0};
        decoded.use_imm = 1'b1;
        decoded.reg_write = 1'b1;
        decoded.alu_op = alu_select(funct3, funct3 == 3'b101 && funct7[5]);
        if (funct3[1:0] == 2'b01) // Shifts keep funct7 in the immediate.
          decoded.halt = !(funct7 == 7'h00 || (funct7 == 7'h20 && funct3[2]));
      end
      cpu_core_pkg::opcode_op: begin
        decoded.reg_write = 1'b1;
        decoded.alu_op = alu_select(funct3, funct7[5]);
        decoded.halt = !(funct7 == 7'h00 ||
                         (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      cpu_core_pkg::opcode_system: decoded.halt = 1'b1; // EBREAK ends the run.
      default: decoded.halt = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: source/register_file.sv
`default_nettype none

module register_file (
  input  wire                              clock,
  input  wire                              reset,
  input  wire [4:0]                        read_addr_a,
  input  wire [4:0]                        read_addr_b,
  output logic [cpu_core_pkg::xlen-1:0]    read_data_a,
  output logic [cpu_core_pkg::xlen-1:0]    read_data_b,
  input  wire                              write_enable,
  input  wire [4:0]                        write_addr,
  input  wire [cpu_core_pkg::xlen-1:0]     write_data
);

  logic [cpu_core_pkg::xlen-1:0] regs [0:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (write_enable && write_addr != 5'd0) begin
      regs[write_addr] <= write_data;
    end
  end

  // Register zero is cleared by reset and never written, so it reads zero.
  assign read_data_a = regs[read_addr_a];
  assign read_data_b = regs[read_addr_b];

  zero_stays_zero: assert property (
    @(posedge clock) disable iff (reset)
    write_enable && write_addr == 5'd0 |=>
      (read_addr_a != 5'd0 || read_data_a == '0) &&
      (read_addr_b != 5'd0 || read_data_b == '0)
  ) else $error("Register zero changed after a write to it.");

endmodule

`default_nettype wire

// File: source/execute_unit.sv
`default_nettype none

module execute_unit (
  input  wire cpu_core_pkg::decoded_instr_t  decoded,
  input  wire [cpu_core_pkg::xlen-1:0]       operand_a,
  input  wire [cpu_core_pkg::xlen-1:0]       operand_b,
  input  wire [cpu_core_pkg::xlen-1:0]       pc,
  output cpu_core_pkg::exec_result_t         result
);

  logic [cpu_core_pkg::xlen-1:0] alu_a;
  logic [cpu_core_pkg::xlen-1:0] alu_b;
  logic [4:0]                    shamt;
  logic [cpu_core_pkg::xlen-1:0] target;
  logic                          equal;
  logic                          less;
  logic                          less_unsigned;

  assign alu_a = decoded.use_pc_a ? pc : operand_a;
  assign alu_b = decoded.use_imm ? decoded.imm : operand_b;
  assign shamt = alu_b[4:0];
  assign target = pc + decoded.imm; // Branch and JAL target.

  // ------------------------------
  // ALU
  // ------------------------------
  always_comb begin
    case (decoded.alu_op)
      cpu_core_pkg::alu_add:    result.alu_value = alu_a + alu_b;
      cpu_core_pkg::alu_sub:    result.alu_value = alu_a - alu_b;
      cpu_core_pkg::alu_sll:    result.alu_value = alu_a << shamt;
      cpu_core_pkg::alu_slt:    result.alu_value = {31'b0, $signed(alu_a) < $signed(alu_b)};
      cpu_core_pkg::alu_sltu:   result.alu_value = {31'b0, alu_a < alu_b};
      cpu_core_pkg::alu_xor:    result.alu_value = alu_a ^ alu_b;
      cpu_core_pkg::alu_srl:    result.alu_value = alu_a >> shamt;
      cpu_core_pkg::alu_sra:    result.alu_value = $signed(alu_a) >>> shamt;
      cpu_core_pkg::alu_or:     result.alu_value = alu_a | alu_b;
      cpu_core_pkg::alu_and:    result.alu_value = alu_a & alu_b;
      cpu_core_pkg::alu_pass_b: result.alu_value = alu_b;
      default:                  result.alu_value = alu_a + alu_b;
    endcase
  end

  // ------------------------------
  // Branch and next pc
  // ------------------------------
  assign equal = operand_a == operand_b;
  assign less = $signed(operand_a) < $signed(operand_b);
  assign less_unsigned = operand_a < operand_b;

  always_comb begin
    case (decoded.rd[2:0]) // Holds funct3 for branches.
      3'b000:  result.taken = decoded.is_branch && equal;
      3'b001:  result.taken = decoded.is_branch && !equal;
      3'b100:  result.taken = decoded.is_branch && less;
      3'b101:  result.taken = decoded.is_branch && !less;
      3'b110:  result.taken = decoded.is_branch && less_unsigned;
      3'b111:  result.taken = decoded.is_branch && !less_unsigned;
      default: result.taken = 1'b0;
    endcase
  end

  assign result.link = pc + 32'd4;

  always_comb begin
    if (decoded.is_jump && decoded.opcode == cpu_core_pkg::opcode_jalr)
      result.next_pc = {result.alu_value[31:1], 1'b0};
    else if (decoded.is_jump || result.taken)
      result.next_pc = target;
    else
      result.next_pc = result.link;
  end

endmodule

`default_nettype wire

// File: source/result_select.sv
`default_nettype none

module result_select (
  input  wire cpu_core_pkg::decoded_instr_t  decoded,
  input  wire cpu_core_pkg::exec_result_t    exec,
  input  wire [cpu_core_pkg::xlen-1:0]       store_source,
  input  wire [cpu_core_pkg::xlen-1:0]       load_word,
  output logic [cpu_core_pkg::xlen-1:0]      store_data,
  output logic [3:0]                         store_sel,
  output logic [cpu_core_pkg::xlen-1:0]      write_data
);

  logic [1:0]                    lane;
  logic [cpu_core_pkg::xlen-1:0] shifted;
  logic [cpu_core_pkg::xlen-1:0] load_value;

  assign lane = exec.alu_value[1:0];
  assign shifted = load_word >> {lane, 3'b000}; // Addressed lane moves to bit 0.

  // The same sel also qualifies loads.
  always_comb begin
    case (decoded.mem_size)
      cpu_core_pkg::size_byte: begin
        store_data = {4{store_source[7:0]}};
        store_sel = 4'b0001 << lane;
      end
      cpu_core_pkg::size_half: begin
        store_data = {2{store_source[15:0]}};
        store_sel = lane[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_data = store_source;
        store_sel = 4'b1111;
      end
    endcase
  end

  always_comb begin
    case (decoded.mem_size)
      cpu_core_pkg::size_byte:
        load_value = {{24{shifted[7] & !decoded.mem_unsigned}}, shifted[7:0]};
      cpu_core_pkg::size_half:
        load_value = {{16{shifted[15] & !decoded.mem_unsigned}}, shifted[15:0]};
      default:
        load_value = load_word;
    endcase
  end

  always_comb begin
    case (decoded.wb_source)
      cpu_core_pkg::wb_memory: write_data = load_value;
      cpu_core_pkg::wb_link:   write_data = exec.link;
      default:                 write_data = exec.alu_value;
    endcase
  end

endmodule

`default_nettype wire

// File: source/core_sequencer.sv
`default_nettype none

module core_sequencer #(
  parameter logic [cpu_core_pkg::xlen-1:0] reset_pc = '0
) (
  input  wire                              clock,
  input  wire                              reset,
  output cpu_core_pkg::instr_word_u        instruction,
  input  wire cpu_core_pkg::decoded_instr_t decoded,
  output logic [4:0]                       rs1,
  output logic [4:0]                       rs2,
  output logic [cpu_core_pkg::xlen-1:0]    pc,
  output cpu_core_pkg::decoded_instr_t     decoded_q,
  input  wire cpu_core_pkg::exec_result_t  exec,
  output cpu_core_pkg::exec_result_t       exec_q,
  input  wire [cpu_core_pkg::xlen-1:0]     store_data,
  input  wire [3:0]                        store_sel,
  output logic [cpu_core_pkg::xlen-1:0]    load_data,
  output logic                             reg_write,
  output cpu_core_pkg::wb_request_t        bus_request,
  input  wire cpu_core_pkg::wb_response_t  bus_response,
  output logic                             halted
);

  typedef enum logic [2:0] {
    st_idle, st_fetch, st_decode, st_execute, st_memory, st_writeback, st_halted
  } state_e;

  state_e state;
  logic   bus_active;
  logic   data_phase;

  // ------------------------------
  // State and pc
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      pc <= reset_pc;
    end else begin
      case (state)
        st_idle:    state <= st_fetch;
        st_fetch:   if (bus_response.ack) state <= st_decode;
        st_decode:  state <= decoded.halt ? st_halted : st_execute;
        st_execute: begin
          if (decoded_q.mem_read || decoded_q.mem_write)
            state <= st_memory;
          else
            state <= st_writeback;
        end
        st_memory:  if (bus_response.ack) state <= st_writeback;
        st_writeback: begin
          pc <= exec_q.next_pc;
          state <= st_fetch;
        end
        default:    state <= st_halted; // Halted is final until reset.
      endcase
    end
  end

  // Payload registers, loaded in the state that produces them.
  always_ff @(posedge clock) begin
    if (state == st_fetch && bus_response.ack)
      instruction <= bus_response.dat;
    if (state == st_decode)
      decoded_q <= decoded;
    if (state == st_execute)
      exec_q <= exec;
    if (state == st_memory && bus_response.ack)
      load_data <= bus_response.dat;
  end

  // The instruction word is held for the whole instruction, so are the read ports.
  assign rs1 = decoded.rs1;
  assign rs2 = decoded.rs2;
  assign reg_write = state == st_writeback && decoded_q.reg_write;
  assign halted = state == st_halted;

  // ------------------------------
  // Wishbone master
  // ------------------------------
  assign data_phase = state == st_memory;
  assign bus_active = state == st_fetch || data_phase;

  always_comb begin
    bus_request.cyc = bus_active;
    bus_request.stb = bus_active;
    bus_request.we = data_phase && decoded_q.mem_write;
    bus_request.adr = data_phase ? {exec_q.alu_value[31:2], 2'b00} : pc;
    bus_request.dat = data_phase ? store_data : '0;
    bus_request.sel = data_phase ? store_sel : 4'b1111;
  end

  stb_within_cyc: assert property (
    @(posedge clock) disable iff (reset) bus_request.stb |-> bus_request.cyc
  ) else $error("Wishbone stb raised without cyc.");

  request_held: assert property (
    @(posedge clock) disable iff (reset)
    bus_request.stb && !bus_response.ack |=> $stable(bus_request)
  ) else $error("Wishbone request changed while waiting for ack.");

  quiet_when_halted: assert property (
    @(posedge clock) disable iff (reset)
    halted |=> halted && !bus_request.cyc && !reg_write
  ) else $error("Bus or register file active after halt.");

endmodule

`default_nettype wire

// File: source/cpu_core.sv
`default_nettype none

module cpu_core #(
  parameter logic [cpu_core_pkg::xlen-1:0] reset_pc = '0
) (
  input  wire                              clock,
  input  wire                              reset,
  output cpu_core_pkg::wb_request_t        bus_request,
  input  wire cpu_core_pkg::wb_response_t  bus_response,
  output logic                             halted
);

  cpu_core_pkg::instr_word_u     instruction;
  cpu_core_pkg::decoded_instr_t  decoded;
  cpu_core_pkg::decoded_instr_t  decoded_q;
  cpu_core_pkg::exec_result_t    exec;
  cpu_core_pkg::exec_result_t    exec_q;
  logic [4:0]                    rs1;
  logic [4:0]                    rs2;
  logic [cpu_core_pkg::xlen-1:0] pc;
  logic [cpu_core_pkg::xlen-1:0] rs1_data;
  logic [cpu_core_pkg::xlen-1:0] rs2_data;
  logic [cpu_core_pkg::xlen-1:0] store_data;
  logic [3:0]                    store_sel;
  logic [cpu_core_pkg::xlen-1:0] load_data;
  logic [cpu_core_pkg::xlen-1:0] write_data;
  logic                          reg_write;

  core_sequencer #(.reset_pc(reset_pc)) sequencer (
    .clock, .reset, .instruction, .decoded, .rs1, .rs2, .pc, .decoded_q,
    .exec, .exec_q, .store_data, .store_sel, .load_data, .reg_write,
    .bus_request, .bus_response, .halted
  );

  instruction_decode decoder (.instruction, .decoded);

  register_file registers (
    .clock,
    .reset,
    .read_addr_a (rs1),
    .read_addr_b (rs2),
    .read_data_a (rs1_data),
    .read_data_b (rs2_data),
    .write_enable(reg_write),
    .write_addr  (decoded_q.rd),
    .write_data  (write_data)
  );

  execute_unit execute (
    .decoded  (decoded_q),
    .operand_a(rs1_data),
    .operand_b(rs2_data),
    .pc,
    .result   (exec)
  );

  result_select results (
    .decoded     (decoded_q),
    .exec        (exec_q),
    .store_source(rs2_data),
    .load_word   (load_data),
    .store_data,
    .store_sel,
    .write_data
  );

endmodule

`default_nettype wire

// File: bench/cpu_core_program.svh
// ------------------------------
// Instruction encoders
// ------------------------------
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [31:0] imm);
  return {imm[11:0], rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [31:0] imm);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [31:0] imm);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                      input logic [19:0] imm);
  return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [31:0] imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

task automatic emit(input logic [31:0] word);
  mem[emit_ptr] = word;
  emit_ptr++;
endtask

task automatic emit_poison();
  poison_adr[poison_total] = emit_ptr * 4;
  poison_total++;
  emit_ptr++;
endtask

task automatic add_store(input logic [31:0] adr, input logic [31:0] dat,
                         input logic [3:0] sel);
  expected_adr[store_total] = adr;
  expected_dat[store_total] = dat;
  expected_sel[store_total] = sel;
  store_total++;
endtask

// ------------------------------
// Program image
// ------------------------------
task automatic load_program();
  for (int i = 0; i < 1024; i++)
    mem[i] = 32'hbad0_0000 | i;
  mem[272] = 32'h80f1_7fa5; // Load source at 0x440.
  emit_ptr = 0;
  poison_total = 0;
  store_total = 0;
  poison_adr[poison_total] = 80 * 4; // Target of every branch that must fall through.
  poison_total++;

  emit(enc_i(7'h13, 3'd0, 5'd10, 5'd0, 1024));
  emit(enc_i(7'h13, 3'd0, 5'd1, 5'd0, -5));
  emit(enc_i(7'h13, 3'd0, 5'd2, 5'd0, 3));
  emit(enc_r(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));   // add: -5 + 3
  emit(enc_s(3'd2, 5'd10, 5'd3, 0));
  emit(enc_r(7'h20, 3'd0, 5'd4, 5'd2, 5'd1));   // sub: 3 - -5
  emit(enc_s(3'd2, 5'd10, 5'd4, 4));
  emit(enc_r(7'h20, 3'd5, 5'd5, 5'd1, 5'd2));   // sra
  emit(enc_i(7'h13, 3'd5, 5'd6, 5'd1, 28));     // srli
  emit(enc_r(7'h00, 3'd2, 5'd7, 5'd1, 5'd2));   // slt
  emit(enc_r(7'h00, 3'd3, 5'd8, 5'd1, 5'd2));   // sltu
  emit(enc_r(7'h00, 3'd4, 5'd9, 5'd5, 5'd6));   // xor
  for (int r = 5; r <= 9; r++)
    emit(enc_s(3'd2, 5'd10, r[4:0], 8 + (r - 5) * 4));
  emit(enc_u(7'h37, 5'd11, 20'h12345));
  emit(enc_i(7'h13, 3'd6, 5'd11, 5'd11, 12'h678));
  emit(enc_u(7'h17, 5'd12, 20'h00001));         // auipc at 0x4c
  emit(enc_s(3'd2, 5'd10, 5'd11, 28));
  emit(enc_s(3'd2, 5'd10, 5'd12, 32));

  // Each condition once taken over a poison word, once falling through.
  emit(enc_b(3'd0, 5'd2, 5'd2, 8));
  emit_poison();
  emit(enc_b(3'd0, 5'd1, 5'd2, (80 - emit_ptr) * 4));
  emit(enc_b(3'd1, 5'd1, 5'd2, 8));
  emit_poison();
  emit(enc_b(3'd1, 5'd2, 5'd2, (80 - emit_ptr) * 4));
  emit(enc_b(3'd4, 5'd1, 5'd2, 8));
  emit_poison();
  emit(enc_b(3'd4, 5'd2, 5'd1, (80 - emit_ptr) * 4));
  emit(enc_b(3'd5, 5'd2, 5'd1, 8));
  emit_poison();
  emit(enc_b(3'd5, 5'd1, 5'd2, (80 - emit_ptr) * 4));
  emit(enc_b(3'd6, 5'd2, 5'd1, 8));
  emit_poison();
  emit(enc_b(3'd6, 5'd1, 5'd2, (80 - emit_ptr) * 4));
  emit(enc_b(3'd7, 5'd1, 5'd2, 8));
  emit_poison();
  emit(enc_b(3'd7, 5'd2, 5'd1, (80 - emit_ptr) * 4));
  emit(enc_j(5'd13, 8));                        // jal at 0xa0
  emit_poison();
  emit(enc_i(7'h13, 3'd0, 5'd14, 5'd0, 187));
  emit(enc_i(7'h67, 3'd0, 5'd15, 5'd14, 6));    // 193 with bit 0 cleared is 0xc0.
  for (int p = 0; p < 4; p++)
    emit_poison();
  emit(enc_s(3'd2, 5'd10, 5'd13, 36));
  emit(enc_s(3'd2, 5'd10, 5'd15, 40));

  emit(enc_i(7'h03, 3'd0, 5'd16, 5'd10, 64));   // lb lane 0
  emit(enc_i(7'h03, 3'd4, 5'd17, 5'd10, 67));   // lbu lane 3
  emit(enc_i(7'h03, 3'd1, 5'd18, 5'd10, 66));   // lh upper half
  emit(enc_i(7'h03, 3'd5, 5'd19, 5'd10, 64));   // lhu lower half
  emit(enc_i(7'h03, 3'd2, 5'd20, 5'd10, 64));
  for (int r = 16; r <= 19; r++)
    emit(enc_s(3'd2, 5'd10, r[4:0], 44 + (r - 16) * 4));
  emit(enc_s(3'd0, 5'd10, 5'd11, 61));
  emit(enc_s(3'd1, 5'd10, 5'd11, 62));
  emit(enc_s(3'd2, 5'd10, 5'd20, 68));
  emit(32'h0010_0073);                          // ebreak

  add_store(32'h400, 32'hffff_fffe, 4'hf);
  add_store(32'h404, 32'h0000_0008, 4'hf);
  add_store(32'h408, 32'hffff_ffff, 4'hf);
  add_store(32'h40c, 32'h0000_000f, 4'hf);
  add_store(32'h410, 32'h0000_0001, 4'hf);
  add_store(32'h414, 32'h0000_0000, 4'hf);
  add_store(32'h418, 32'hffff_fff0, 4'hf);
  add_store(32'h41c, 32'h1234_5678, 4'hf);
  add_store(32'h420, 32'h0000_104c, 4'hf);
  add_store(32'h424, 32'h0000_00a4, 4'hf);
  add_store(32'h428, 32'h0000_00b0, 4'hf);
  add_store(32'h42c, 32'hffff_ffa5, 4'hf);
  add_store(32'h430, 32'h0000_0080, 4'hf);
  add_store(32'h434, 32'hffff_80f1, 4'hf);
  add_store(32'h438, 32'h0000_7fa5, 4'hf);
  add_store(32'h43c, 32'h7878_7878, 4'b0010);
  add_store(32'h43c, 32'h5678_5678, 4'b1100);
  add_store(32'h444, 32'h80f1_7fa5, 4'hf);
endtask

// File: bench/cpu_core_tb.sv
`default_nettype none

module cpu_core_tb;

  logic                       clock;
  logic                       reset;
  cpu_core_pkg::wb_request_t  bus_request;
  cpu_core_pkg::wb_response_t bus_response;
  logic                       halted;

  logic [31:0] mem [0:1023];
  logic [31:0] expected_adr [0:31];
  logic [31:0] expected_dat [0:31];
  logic [3:0]  expected_sel [0:31];
  logic [31:0] poison_adr [0:31];
  int          store_total;
  int          store_index;
  int          poison_total;
  int          emit_ptr;
  int          cycle_count;
  logic        request_seen;
  logic        model_active;
  logic [1:0]  model_delay;
  logic [31:0] lcg_state;

  `include "cpu_core_program.svh"

  cpu_core #(.reset_pc(32'h0)) DUT (.clock, .reset, .bus_request, .bus_response, .halted);

  initial clock = 1'b0;
  always #4 clock = ~clock;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic is_poison(input logic [31:0] adr);
    for (int i = 0; i < poison_total; i++)
      if (poison_adr[i] == adr)
        return 1'b1;
    return 1'b0;
  endfunction

  task automatic stop_failed();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped after a failure.");
  endtask

  task automatic report_error(input string msg);
    $display("error: %0t %s", $time, msg);
    stop_failed();
  endtask

  // ------------------------------
  // Memory model
  // ------------------------------
  always @(posedge clock) begin
    if (reset) begin
      bus_response <= '0;
      model_active <= 1'b0;
    end else if (bus_response.ack) begin
      bus_response.ack <= 1'b0; // One ack per request.
      model_active <= 1'b0;
    end else if (bus_request.stb) begin
      if (!model_active) begin
        model_active <= 1'b1;
        lcg_state = lcg_next(lcg_state);
        model_delay <= lcg_state[31:30];
      end else if (model_delay == 2'd0) begin
        bus_response.ack <= 1'b1;
        bus_response.dat <= mem[bus_request.adr[11:2]];
        for (int b = 0; b < 4; b++)
          if (bus_request.we && bus_request.sel[b])
            mem[bus_request.adr[11:2]][8*b +: 8] <= bus_request.dat[8*b +: 8];
      end else begin
        model_delay <= model_delay - 2'd1;
      end
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (bus_request.stb)
      request_seen <= 1'b1;
    if (!reset && bus_request.we && bus_response.ack)
      store_index <= store_index + 1;
  end

  // ------------------------------
  // Checks
  // ------------------------------
  quiet_in_reset: assert property (@(posedge clock)
    (reset && cycle_count > 0) || $fell(reset) |-> !bus_request.cyc && !bus_request.stb && !halted)
    else report_error("bus or halted active around reset");

  first_request: assert property (@(posedge clock) disable iff (reset)
    bus_request.stb && !request_seen |-> !bus_request.we && bus_request.sel == 4'hf &&
      bus_request.adr == 32'h0)
    else report_error("first request is not a full read at address 0");

  stb_needs_cyc: assert property (@(posedge clock) bus_request.stb |-> bus_request.cyc)
    else report_error("stb without cyc");

  request_stable: assert property (@(posedge clock) disable iff (reset)
    bus_request.stb && !bus_response.ack |=> $stable(bus_request))
    else report_error("request changed before ack");

  fetch_shape: assert property (@(posedge clock) disable iff (reset)
    bus_request.stb && bus_request.adr < 32'h400 |-> !bus_request.we && bus_request.sel == 4'hf)
    else report_error("program area access is not a full read");

  no_poison: assert property (@(posedge clock) disable iff (reset)
    bus_request.stb |-> !is_poison(bus_request.adr))
    else report_error("request reached a poison word");

  store_match: assert property (@(posedge clock) disable iff (reset)
    bus_request.we && bus_response.ack |-> store_index < store_total &&
      bus_request.adr == expected_adr[store_index] &&
      bus_request.dat == expected_dat[store_index] &&
      bus_request.sel == expected_sel[store_index])
    else report_error($sformatf("store %0d wrong: adr %h dat %h sel %b", store_index,
                                bus_request.adr, bus_request.dat, bus_request.sel));

  halt_is_final: assert property (@(posedge clock) disable iff (reset)
    halted |=> halted && !bus_request.cyc)
    else report_error("core left halt or used the bus");

  // ------------------------------
  // Stimulus and end of run
  // ------------------------------
  initial begin
    reset = 1'b1;
    bus_response = '0;
    cycle_count = 0;
    store_index = 0;
    request_seen = 1'b0;
    model_active = 1'b0;
    model_delay = 2'd0;
    lcg_state = 32'hd02f_dedd;
    load_program();
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    while (!halted)
      @(posedge clock);
    repeat (8) @(posedge clock);
    if (store_index == store_total) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("error: %0t only %0d of %0d stores seen", $time, store_index, store_total);
      stop_failed();
    end
  end

  initial begin
    #1;
    #((emit_ptr * 60 + 16) * 8);
    $display("Timeout: the core did not halt in time.");
    stop_failed();
  end

endmodule

`default_nettype wire

// File: cpu_core.f
+incdir+bench
source/cpu_core_pkg.sv
source/instruction_decode.sv
source/register_file.sv
source/execute_unit.sv
source/result_select.sv
source/core_sequencer.sv
source/cpu_core.sv
bench/cpu_core_tb.sv
